//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

  //**************************************************************************
  // Widths and CSR addresses
  //**************************************************************************

  localparam int xlen       = 32;
  localparam int csr_addr_w = 12;

  localparam logic [csr_addr_w-1:0] addr_mstatus = 12'h300;
  localparam logic [csr_addr_w-1:0] addr_mtvec   = 12'h305;
  localparam logic [csr_addr_w-1:0] addr_mepc    = 12'h341;
  localparam logic [csr_addr_w-1:0] addr_mcause  = 12'h342;

  // mstatus bit positions
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;

  // Environment call from M-mode
  localparam logic [xlen-1:0] cause_ecall_m = 32'd11;

  // Storage slots inside the CSR file, slot 0 catches unknown addresses
  localparam int slot_w       = 3;
  localparam int num_slots    = 5;
  localparam logic [slot_w-1:0] slot_dummy   = 3'd0;
  localparam logic [slot_w-1:0] slot_mstatus = 3'd1;
  localparam logic [slot_w-1:0] slot_mtvec   = 3'd2;
  localparam logic [slot_w-1:0] slot_mepc    = 3'd3;
  localparam logic [slot_w-1:0] slot_mcause  = 3'd4;

  //**************************************************************************
  // Opcodes and update kinds
  //**************************************************************************

  typedef enum logic [2:0] {
    op_none  = 3'd0,
    op_csrrw = 3'd1,
    op_csrrs = 3'd2,
    op_csrrc = 3'd3,
    op_ecall = 3'd4,
    op_mret  = 3'd5
  } csr_op_e;

  typedef enum logic [1:0] {
    upd_none        = 2'd0,
    upd_trap_enter  = 2'd1,
    upd_trap_return = 2'd2
  } mstatus_upd_e;

  //**************************************************************************
  // Request structs
  //**************************************************************************

  // One system instruction from execute, operand is the rs1 value
  typedef struct packed {
    csr_op_e               op;
    logic [csr_addr_w-1:0] addr;
    logic [xlen-1:0]       operand;
    logic [xlen-1:0]       pc;
  } csr_req_t;

  typedef struct packed {
    logic                  en;
    logic [csr_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } csr_wr_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

//--- verilog/csr_rmw.sv
`timescale 1ns/1ps
`default_nettype none

module csr_rmw (
  input  wire                             valid,
  input  wire csr_pkg::csr_req_t          req,
  input  wire logic [csr_pkg::xlen-1:0]   old_data,
  output csr_pkg::csr_wr_t                wr
);

  logic                     is_csr_op;
  logic [csr_pkg::xlen-1:0] new_data;

  // Replace, set or clear against the current CSR value
  always_comb begin
    is_csr_op = 1'b1;
    new_data  = old_data;
    case (req.op)
      csr_pkg::op_csrrw: begin
        new_data = req.operand;
      end
      csr_pkg::op_csrrs: begin
        new_data = old_data | req.operand;
      end
      csr_pkg::op_csrrc: begin
        new_data = old_data & ~req.operand;
      end
      default: begin
        is_csr_op = 1'b0;
      end
    endcase
  end

  always_comb begin
    wr.en   = valid & is_csr_op;
    wr.addr = req.addr;
    wr.data = new_data;
  end

  // A valid strobe must carry one of the defined opcodes
  always_comb begin
    assert final (!valid || req.op inside {csr_pkg::op_none, csr_pkg::op_csrrw,
                                           csr_pkg::op_csrrs, csr_pkg::op_csrrc,
                                           csr_pkg::op_ecall, csr_pkg::op_mret})
      else $error("csr_rmw: unknown opcode %0d with valid high", req.op);
  end

endmodule

`default_nettype wire

//--- verilog/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
  input  wire                             valid,
  input  wire csr_pkg::csr_req_t          req,
  input  wire logic [csr_pkg::xlen-1:0]   mtvec,
  input  wire logic [csr_pkg::xlen-1:0]   mepc,
  output csr_pkg::csr_wr_t                wr0,
  output csr_pkg::csr_wr_t                wr1,
  output csr_pkg::mstatus_upd_e           upd,
  output csr_pkg::redirect_t              redirect
);

  logic is_ecall;
  logic is_mret;

  assign is_ecall = valid && (req.op == csr_pkg::op_ecall);
  assign is_mret  = valid && (req.op == csr_pkg::op_mret);

  //**************************************************************************
  // Trap entry writes
  //**************************************************************************

  // mepc takes the pc of the ECALL itself
  always_comb begin
    wr0.en   = is_ecall;
    wr0.addr = csr_pkg::addr_mepc;
    wr0.data = req.pc;
  end

  always_comb begin
    wr1.en   = is_ecall;
    wr1.addr = csr_pkg::addr_mcause;
    wr1.data = csr_pkg::cause_ecall_m;
  end

  always_comb begin
    if (is_ecall) begin
      upd = csr_pkg::upd_trap_enter;
    end else if (is_mret) begin
      upd = csr_pkg::upd_trap_return;
    end else begin
      upd = csr_pkg::upd_none;
    end
  end

  //**************************************************************************
  // Fetch redirect
  //**************************************************************************

  // Direct mode only, mode bits of mtvec are dropped
  always_comb begin
    redirect.taken = is_ecall | is_mret;
    if (is_ecall) begin
      redirect.target = {mtvec[csr_pkg::xlen-1:2], 2'b00};
    end else if (is_mret) begin
      redirect.target = mepc;
    end else begin
      redirect.target = '0;
    end
  end

  always_comb begin
    assert final (!redirect.taken || valid)
      else $error("trap_ctrl: redirect taken without valid");
  end

endmodule

`default_nettype wire

//--- verilog/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire logic [csr_pkg::csr_addr_w-1:0]   raddr,
  output logic [csr_pkg::xlen-1:0]              rdata,
  input  wire csr_pkg::csr_wr_t                 wr_a,
  input  wire csr_pkg::csr_wr_t                 wr_b,
  input  wire csr_pkg::csr_wr_t                 wr_c,
  input  wire csr_pkg::mstatus_upd_e            upd,
  output logic [csr_pkg::xlen-1:0]              mtvec,
  output logic [csr_pkg::xlen-1:0]              mepc
);

  logic [csr_pkg::xlen-1:0]   csr_q [csr_pkg::num_slots];
  logic [csr_pkg::slot_w-1:0] rd_slot;
  logic [csr_pkg::slot_w-1:0] wr0_slot;
  logic [csr_pkg::slot_w-1:0] wr1_slot;
  csr_pkg::csr_wr_t           port0;
  csr_pkg::csr_wr_t           port1;

  function automatic logic [csr_pkg::slot_w-1:0] slot_of(
    input logic [csr_pkg::csr_addr_w-1:0] addr
  );
    logic [csr_pkg::slot_w-1:0] slot;
    case (addr)
      csr_pkg::addr_mstatus: slot = csr_pkg::slot_mstatus;
      csr_pkg::addr_mtvec:   slot = csr_pkg::slot_mtvec;
      csr_pkg::addr_mepc:    slot = csr_pkg::slot_mepc;
      csr_pkg::addr_mcause:  slot = csr_pkg::slot_mcause;
      default:               slot = csr_pkg::slot_dummy;
    endcase
    return slot;
  endfunction

  //**************************************************************************
  // Read side
  //**************************************************************************

  assign rd_slot = slot_of(raddr);

  // Unknown addresses read as zero
  assign rdata = (rd_slot == csr_pkg::slot_dummy) ? '0 : csr_q[rd_slot];
  assign mtvec = csr_q[csr_pkg::slot_mtvec];
  assign mepc  = csr_q[csr_pkg::slot_mepc];

  //**************************************************************************
  // Write side
  //**************************************************************************

  // Port 0 carries either the RMW request or the mepc write
  assign port0 = wr_a.en ? wr_a : wr_b;
  assign port1 = wr_c;

  assign wr0_slot = slot_of(port0.addr);
  assign wr1_slot = slot_of(port1.addr);

  // Writes to unknown addresses land in the dummy slot
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < csr_pkg::num_slots; i++) begin
        csr_q[i] <= '0;
      end
    end else begin
      if (port0.en) begin
        csr_q[wr0_slot] <= port0.data;
      end
      if (port1.en) begin
        csr_q[wr1_slot] <= port1.data;
      end
      // Trap update comes last so it wins on MIE and MPIE
      case (upd)
        csr_pkg::upd_trap_enter: begin
          csr_q[csr_pkg::slot_mstatus][csr_pkg::mstatus_mpie] <=
            csr_q[csr_pkg::slot_mstatus][csr_pkg::mstatus_mie];
          csr_q[csr_pkg::slot_mstatus][csr_pkg::mstatus_mie] <= 1'b0;
        end
        csr_pkg::upd_trap_return: begin
          csr_q[csr_pkg::slot_mstatus][csr_pkg::mstatus_mie] <=
            csr_q[csr_pkg::slot_mstatus][csr_pkg::mstatus_mpie];
          csr_q[csr_pkg::slot_mstatus][csr_pkg::mstatus_mpie] <= 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  //**************************************************************************
  // Checks
  //**************************************************************************

  // RMW and trap requests come from different opcodes
  a_rmw_trap_excl: assert property (
    @(posedge clk) disable iff (rst)
    wr_a.en |-> !(wr_b.en || wr_c.en)
  ) else $error("csr_file: RMW write collides with a trap write");

  a_trap_addr_distinct: assert property (
    @(posedge clk) disable iff (rst)
    (wr_b.en && wr_c.en) |-> (wr_b.addr != wr_c.addr)
  ) else $error("csr_file: both trap writes target one CSR");

endmodule

`default_nettype wire

//--- verilog/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             valid,
  input  wire csr_pkg::csr_req_t          req,
  output logic [csr_pkg::xlen-1:0]        rdata,
  output csr_pkg::redirect_t              redirect,
  output logic [csr_pkg::xlen-1:0]        mtvec,
  output logic [csr_pkg::xlen-1:0]        mepc
);

  csr_pkg::csr_wr_t      rmw_wr;
  csr_pkg::csr_wr_t      trap_wr0;
  csr_pkg::csr_wr_t      trap_wr1;
  csr_pkg::mstatus_upd_e upd;

  //**************************************************************************
  // CSR storage
  //**************************************************************************

  csr_file csr_file0 (
    .clk   (clk),
    .rst   (rst),
    .raddr (req.addr),
    .rdata (rdata),
    .wr_a  (rmw_wr),
    .wr_b  (trap_wr0),
    .wr_c  (trap_wr1),
    .upd   (upd),
    .mtvec (mtvec),
    .mepc  (mepc)
  );

  // CSR instructions, old value comes straight from the read port
  csr_rmw csr_rmw0 (
    .valid    (valid),
    .req      (req),
    .old_data (rdata),
    .wr       (rmw_wr)
  );

  // ECALL and MRET
  trap_ctrl trap_ctrl0 (
    .valid    (valid),
    .req      (req),
    .mtvec    (mtvec),
    .mepc     (mepc),
    .wr0      (trap_wr0),
    .wr1      (trap_wr1),
    .upd      (upd),
    .redirect (redirect)
  );

endmodule

`default_nettype wire

//--- bench/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Reference copies of the four machine-mode CSRs
logic [csr_pkg::xlen-1:0] model_mstatus;
logic [csr_pkg::xlen-1:0] model_mtvec;
logic [csr_pkg::xlen-1:0] model_mepc;
logic [csr_pkg::xlen-1:0] model_mcause;

task automatic model_reset();
  model_mstatus = '0;
  model_mtvec   = '0;
  model_mepc    = '0;
  model_mcause  = '0;
endtask

// Unknown addresses read as zero
function automatic logic [csr_pkg::xlen-1:0] model_read(
  input logic [csr_pkg::csr_addr_w-1:0] addr
);
  logic [csr_pkg::xlen-1:0] value;
  value = '0;
  if (addr == 12'h300) value = model_mstatus;
  if (addr == 12'h305) value = model_mtvec;
  if (addr == 12'h341) value = model_mepc;
  if (addr == 12'h342) value = model_mcause;
  return value;
endfunction

task automatic model_write(
  input logic [csr_pkg::csr_addr_w-1:0] addr,
  input logic [csr_pkg::xlen-1:0]       data
);
  if (addr == 12'h300) model_mstatus = data;
  if (addr == 12'h305) model_mtvec   = data;
  if (addr == 12'h341) model_mepc    = data;
  if (addr == 12'h342) model_mcause  = data;
endtask

// ECALL jumps to the aligned trap vector, MRET back to mepc
function automatic csr_pkg::redirect_t model_redirect(
  input logic              v,
  input csr_pkg::csr_req_t r
);
  csr_pkg::redirect_t exp;
  exp = '0;
  if (v && r.op == csr_pkg::op_ecall) begin
    exp.taken  = 1'b1;
    exp.target = model_mtvec & ~32'h3;
  end else if (v && r.op == csr_pkg::op_mret) begin
    exp.taken  = 1'b1;
    exp.target = model_mepc;
  end
  return exp;
endfunction

// State after the edge that ends this cycle
task automatic model_update(input logic v, input csr_pkg::csr_req_t r);
  logic [csr_pkg::xlen-1:0] old;
  logic                     mie;
  logic                     mpie;
  old  = model_read(r.addr);
  mie  = model_mstatus[3];
  mpie = model_mstatus[7];
  if (v) begin
    case (r.op)
      csr_pkg::op_csrrw: model_write(r.addr, r.operand);
      csr_pkg::op_csrrs: model_write(r.addr, old | r.operand);
      csr_pkg::op_csrrc: model_write(r.addr, old & ~r.operand);
      csr_pkg::op_ecall: begin
        model_mepc       = r.pc;
        model_mcause     = 32'd11;
        model_mstatus[7] = mie;
        model_mstatus[3] = 1'b0;
      end
      csr_pkg::op_mret: begin
        model_mstatus[3] = mpie;
        model_mstatus[7] = 1'b1;
      end
      default: begin
      end
    endcase
  end
endtask

`endif

//--- bench/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

  localparam int num_instr     = 3000;
  localparam int reset_timeout = 40;

  logic                     clk;
  logic                     rst;
  logic                     valid;
  csr_pkg::csr_req_t        req;
  logic [csr_pkg::xlen-1:0] rdata;
  csr_pkg::redirect_t       redirect;
  logic [csr_pkg::xlen-1:0] mtvec;
  logic [csr_pkg::xlen-1:0] mepc;

  logic [31:0] rng_state = 32'd57;

  `include "csr_model.svh"

  csr_unit dut0 (
    .clk      (clk),
    .rst      (rst),
    .valid    (valid),
    .req      (req),
    .rdata    (rdata),
    .redirect (redirect),
    .mtvec    (mtvec),
    .mepc     (mepc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst   = 1'b1;
    valid = 1'b0;
    req   = '0;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
  end

  //**************************************************************************
  // Checks and random numbers
  //**************************************************************************

  task automatic stop_with_failure();
    $display("sim failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic compare_data(
    input string                    name,
    input logic [csr_pkg::xlen-1:0] got,
    input logic [csr_pkg::xlen-1:0] exp
  );
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // The target only matters when the redirect is taken
  task automatic compare_redirect(
    input string              name,
    input csr_pkg::redirect_t got,
    input csr_pkg::redirect_t exp
  );
    if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
      $display("FAILED at %0t: %s got taken=%b target=%h expected taken=%b target=%h",
               $time, name, got.taken, got.target, exp.taken, exp.target);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r         = rng_state;
  endtask

  function automatic csr_pkg::csr_req_t make_req(
    input csr_pkg::csr_op_e               op,
    input logic [csr_pkg::csr_addr_w-1:0] addr,
    input logic [csr_pkg::xlen-1:0]       operand,
    input logic [csr_pkg::xlen-1:0]       pc
  );
    csr_pkg::csr_req_t r;
    r.op      = op;
    r.addr    = addr;
    r.operand = operand;
    r.pc      = pc;
    return r;
  endfunction

  // Mostly CSR ops on the four known addresses
  task automatic random_req(output csr_pkg::csr_req_t r);
    logic [31:0]                   sel;
    logic [31:0]                   pick;
    logic [31:0]                   operand;
    logic [31:0]                   pc;
    csr_pkg::csr_op_e              op;
    logic [csr_pkg::csr_addr_w-1:0] addr;
    next_random(sel);
    next_random(pick);
    next_random(operand);
    next_random(pc);
    if (sel[3:0] == 4'd0) op = csr_pkg::op_none;
    else if (sel[3:0] <= 4'd4) op = csr_pkg::op_csrrw;
    else if (sel[3:0] <= 4'd8) op = csr_pkg::op_csrrs;
    else if (sel[3:0] <= 4'd12) op = csr_pkg::op_csrrc;
    else if (sel[3:0] <= 4'd14) op = csr_pkg::op_ecall;
    else op = csr_pkg::op_mret;
    if (pick[3:0] < 4'd13) begin
      case (pick[5:4])
        2'd0: addr = 12'h300;
        2'd1: addr = 12'h305;
        2'd2: addr = 12'h341;
        default: addr = 12'h342;
      endcase
    end else begin
      addr = pick[27:16];
    end
    r = make_req(op, addr, operand, pc);
  endtask

  //**************************************************************************
  // One cycle of stimulus, entered and left on a rising edge
  //**************************************************************************

  task automatic issue(input logic v, input csr_pkg::csr_req_t r);
    #1;
    valid = v;
    req   = r;
    #2;
    compare_data("rdata", rdata, model_read(r.addr));
    compare_redirect("redirect", redirect, model_redirect(v, r));
    compare_data("mtvec", mtvec, model_mtvec);
    compare_data("mepc", mepc, model_mepc);
    @(posedge clk);
    model_update(v, r);
  endtask

  task automatic read_csr(input logic [csr_pkg::csr_addr_w-1:0] addr);
    issue(1'b0, make_req(csr_pkg::op_ecall, addr, 32'hffff_ffff, 32'h0));
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (rst) begin
      if (cycles >= reset_timeout) begin
        $display("reset was not released in time");
        stop_with_failure();
      end
      @(posedge clk);
      cycles++;
    end
  endtask

  initial begin
    csr_pkg::csr_req_t r;
    logic [31:0]       gap;
    model_reset();
    wait_reset_release();

    // Reset values read with an ECALL opcode held while valid is low
    read_csr(12'h300);
    read_csr(12'h305);
    read_csr(12'h341);
    read_csr(12'h342);

    // Trap entry and return with MIE set
    issue(1'b1, make_req(csr_pkg::op_csrrw, 12'h305, 32'h0000_1003, 32'h10));
    issue(1'b1, make_req(csr_pkg::op_csrrw, 12'h300, 32'h0000_0008, 32'h14));
    read_csr(12'h300);
    issue(1'b1, make_req(csr_pkg::op_ecall, 12'h300, 32'h0, 32'h0000_0200));
    read_csr(12'h300);
    read_csr(12'h341);
    read_csr(12'h342);
    issue(1'b1, make_req(csr_pkg::op_mret, 12'h300, 32'h0, 32'h0000_1000));
    read_csr(12'h300);

    // Set, clear and a write to an unknown address
    issue(1'b1, make_req(csr_pkg::op_csrrs, 12'h342, 32'hf0f0_0000, 32'h0));
    issue(1'b1, make_req(csr_pkg::op_csrrc, 12'h342, 32'h3000_0001, 32'h0));
    read_csr(12'h342);
    issue(1'b1, make_req(csr_pkg::op_csrrw, 12'h7c0, 32'hdead_beef, 32'h0));
    read_csr(12'h7c0);
    read_csr(12'h300);
    read_csr(12'h305);
    read_csr(12'h341);
    read_csr(12'h342);

    // Random back-to-back traffic with the odd idle cycle
    for (int i = 0; i < num_instr; i++) begin
      next_random(gap);
      if (gap[2:0] == 3'd0) begin
        random_req(r);
        issue(1'b0, r);
      end
      random_req(r);
      issue(1'b1, r);
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
verilog/csr_pkg.sv
verilog/csr_rmw.sv
verilog/trap_ctrl.sv
verilog/csr_file.sv
verilog/csr_unit.sv
bench/csr_unit_tb.sv
